// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_scalar_core
FILELIST = scalar_core.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = ERRORS FOUND
PASS_MSG = NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Each program: words, length and a step limit for the reference run.
// An ADDI with immediate RAND gets an LFSR value before it is stored.
task automatic load_programs();
	// ALU opcodes on random operands
	prog_words[0][0] = enc_imm(OP_ADDI, 1, 0, RAND);
	prog_words[0][1] = enc_imm(OP_ADDI, 2, 0, RAND);
	prog_words[0][2] = enc_reg(OP_ADD, 3, 1, 2);
	prog_words[0][3] = enc_reg(OP_SUB, 4, 1, 2);
	prog_words[0][4] = enc_reg(OP_AND, 5, 3, 4);
	prog_words[0][5] = enc_reg(OP_OR, 6, 3, 4);
	prog_words[0][6] = enc_reg(OP_XOR, 7, 5, 6);
	prog_words[0][7] = enc_imm(OP_HALT, 0, 0, 0);
	prog_len[0]      = 8;
	prog_steps[0]    = 16;

	// Dependency distances 1 to 4, writes to and reads of r0
	prog_words[1][0] = enc_imm(OP_ADDI, 1, 0, RAND);
	prog_words[1][1] = enc_imm(OP_ADDI, 1, 1, RAND);
	prog_words[1][2] = enc_reg(OP_ADD, 2, 1, 1);
	prog_words[1][3] = enc_imm(OP_ADDI, 0, 1, RAND);
	prog_words[1][4] = enc_reg(OP_ADD, 3, 0, 2);
	prog_words[1][5] = enc_reg(OP_SUB, 4, 3, 1);
	prog_words[1][6] = enc_reg(OP_XOR, 5, 2, 4);
	prog_words[1][7] = enc_reg(OP_AND, 6, 3, 5);
	prog_words[1][8] = enc_reg(OP_OR, 7, 4, 0);
	prog_words[1][9] = enc_imm(OP_HALT, 0, 0, 0);
	prog_len[1]      = 10;
	prog_steps[1]    = 16;

	// Counted loop, jump over dead code, branch not taken
	prog_words[2][0]  = enc_imm(OP_ADDI, 1, 0, 3);
	prog_words[2][1]  = enc_imm(OP_ADDI, 2, 0, RAND);
	prog_words[2][2]  = enc_imm(OP_ADDI, 3, 0, 1);
	prog_words[2][3]  = enc_reg(OP_ADD, 3, 3, 2);
	prog_words[2][4]  = enc_imm(OP_ADDI, 1, 1, -1);
	prog_words[2][5]  = enc_imm(OP_BNZ, 0, 1, 3);
	prog_words[2][6]  = enc_imm(OP_JMP, 0, 0, 9);
	prog_words[2][7]  = enc_imm(OP_ADDI, 4, 0, 7);
	prog_words[2][8]  = enc_imm(OP_ADDI, 5, 0, 8);
	prog_words[2][9]  = enc_imm(OP_BNZ, 0, 0, 12);
	prog_words[2][10] = enc_reg(OP_XOR, 6, 3, 1);
	prog_words[2][11] = enc_imm(OP_HALT, 0, 0, 0);
	prog_words[2][12] = enc_imm(OP_ADDI, 7, 0, 5);
	prog_words[2][13] = enc_imm(OP_ADDI, 8, 0, 6);
	prog_len[2]       = 14;
	prog_steps[2]     = 32;

	// Unused opcode, then halt with live code behind it
	prog_words[3][0] = enc_imm(OP_ADDI, 9, 0, RAND);
	prog_words[3][1] = enc_reg(OP_NONE, 1, 2, 3);
	prog_words[3][2] = enc_imm(OP_ADDI, 10, 9, 5);
	prog_words[3][3] = enc_imm(OP_HALT, 0, 0, 0);
	prog_words[3][4] = enc_imm(OP_ADDI, 11, 0, 1);
	prog_words[3][5] = enc_reg(OP_ADD, 12, 9, 9);
	prog_words[3][6] = enc_imm(OP_JMP, 0, 0, 0);
	prog_len[3]      = 7;
	prog_steps[3]    = 10;
endtask

`endif

// ==== dv/tb_scalar_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_scalar_core
	import scalar_pkg::*;
();

	localparam int ADDR_WIDTH   = 6;
	localparam int NUM_REGS     = 2 ** REG_INDEX_WIDTH;
	localparam int NUM_PROGS    = 4;
	localparam int MAX_LEN      = 16;
	localparam int DRIVE_DELAY  = 10;
	localparam int RESET_CYCLES = 10;
	localparam int ACK_WAIT     = 8;
	localparam int TAIL_CYCLES  = 6;
	localparam int RAND         = 0;

	localparam logic [OPCODE_WIDTH-1:0] OP_NONE = 4'h0;
	localparam logic [31:0]             LFSR_SEED = 32'ha10b5832;

	logic                       clock = 1'b0;
	logic                       reset;
	logic                       run;
	logic                       st_req;
	logic [ADDR_WIDTH-1:0]      st_addr;
	instr_u                     st_instr;
	logic                       st_ack;
	logic                       wb_valid;
	logic [REG_INDEX_WIDTH-1:0] wb_index;
	logic [DATA_WIDTH-1:0]      wb_data;
	logic                       term;

	instr_u prog_words [NUM_PROGS][MAX_LEN];
	int     prog_len   [NUM_PROGS];
	int     prog_steps [NUM_PROGS];

	// Expected write-backs of the program being run
	logic [REG_INDEX_WIDTH-1:0] want_index [$];
	logic [DATA_WIDTH-1:0]      want_data [$];

	logic [31:0] lfsr_state;
	int          error_count = 0;
	int          check_count = 0;
	int          timeout_cycles = 0;
	int          current_prog = 0;

	always #50 clock = ~clock;

	scalar_core #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) i_dut (
		.clock    (clock),
		.reset    (reset),
		.run      (run),
		.st_req   (st_req),
		.st_addr  (st_addr),
		.st_instr (st_instr),
		.st_ack   (st_ack),
		.wb_valid (wb_valid),
		.wb_index (wb_index),
		.wb_data  (wb_data),
		.term     (term)
	);

	//////////////////////////////////////////////////////////////////////
	// Instruction encoding and random immediates
	//////////////////////////////////////////////////////////////////////

	function automatic instr_u enc_reg(input logic [OPCODE_WIDTH-1:0] op, input int dst,
		input int src1, input int src2);
		instr_u w;
		w = '0;
		w.reg_fmt.opcode = op;
		w.reg_fmt.dst    = REG_INDEX_WIDTH'(dst);
		w.reg_fmt.src1   = REG_INDEX_WIDTH'(src1);
		w.reg_fmt.src2   = REG_INDEX_WIDTH'(src2);
		return w;
	endfunction

	function automatic instr_u enc_imm(input logic [OPCODE_WIDTH-1:0] op, input int dst,
		input int src1, input int imm);
		instr_u w;
		w.imm_fmt.opcode = op;
		w.imm_fmt.dst    = REG_INDEX_WIDTH'(dst);
		w.imm_fmt.src1   = REG_INDEX_WIDTH'(src1);
		w.imm_fmt.imm    = IMM_WIDTH'(imm);
		return w;
	endfunction

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic take_bits(input int count, output logic [DATA_WIDTH-1:0] value);
		value = '0;
		repeat (count) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[DATA_WIDTH-2:0], lfsr_state[0]};
		end
	endtask

	`include "tb_programs.svh"

	task automatic fill_immediates();
		logic [DATA_WIDTH-1:0] bits;
		for (int p = 0; p < NUM_PROGS; p++) begin
			for (int i = 0; i < prog_len[p]; i++) begin
				if (prog_words[p][i].imm_fmt.opcode == OP_ADDI &&
						prog_words[p][i].imm_fmt.imm == '0) begin
					take_bits(IMM_WIDTH, bits);
					prog_words[p][i].imm_fmt.imm = bits[IMM_WIDTH-1:0];
				end
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	task automatic report_failure(input string what);
		error_count++;
		$display("Failure in program %0d: %s", current_prog, what);
	endtask

	task automatic check_wb(input logic [REG_INDEX_WIDTH-1:0] got_index,
		input logic [DATA_WIDTH-1:0] got_data, input logic [REG_INDEX_WIDTH-1:0] exp_index,
		input logic [DATA_WIDTH-1:0] exp_data);
		check_count++;
		if (got_index !== exp_index) begin
			error_count++;
			$display("Error: wb_index got %h expected %h", got_index, exp_index);
		end
		if (got_data !== exp_data) begin
			error_count++;
			$display("Error: wb_data got %h expected %h", got_data, exp_data);
		end
	endtask

	task automatic check_instr(input int addr, input instr_u got, input instr_u exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Error: mem[%0d] got %h expected %h", addr, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference interpreter
	//////////////////////////////////////////////////////////////////////

	task automatic interpret(input int p);
		logic [DATA_WIDTH-1:0] regs [NUM_REGS];
		logic [DATA_WIDTH-1:0] a;
		logic [DATA_WIDTH-1:0] b;
		logic [DATA_WIDTH-1:0] imm_ext;
		logic [DATA_WIDTH-1:0] result;
		instr_u                w;
		int                    pc;
		int                    steps;
		bit                    halted;
		bit                    is_write;
		want_index.delete();
		want_data.delete();
		foreach (regs[r]) regs[r] = '0;
		pc     = 0;
		steps  = 0;
		halted = 1'b0;
		while (!halted && steps < prog_steps[p]) begin
			w = '0;
			if (pc < prog_len[p]) w = prog_words[p][pc];
			// src1 sits at the same bits in both views
			a        = regs[w.reg_fmt.src1];
			b        = regs[w.reg_fmt.src2];
			imm_ext  = DATA_WIDTH'($signed(w.imm_fmt.imm));
			result   = '0;
			is_write = 1'b1;
			pc       = pc + 1;
			steps++;
			case (w.reg_fmt.opcode)
				OP_ADD:  result = a + b;
				OP_SUB:  result = a - b;
				OP_AND:  result = a & b;
				OP_OR:   result = a | b;
				OP_XOR:  result = a ^ b;
				OP_ADDI: result = a + imm_ext;
				OP_JMP: begin
					is_write = 1'b0;
					pc = int'(w.imm_fmt.imm);
				end
				OP_BNZ: begin
					is_write = 1'b0;
					if (a != '0) pc = int'(w.imm_fmt.imm);
				end
				OP_HALT: begin
					is_write = 1'b0;
					halted = 1'b1;
				end
				default: is_write = 1'b0;
			endcase
			if (is_write && w.reg_fmt.dst != '0) begin
				regs[w.reg_fmt.dst] = result;
				want_index.push_back(w.reg_fmt.dst);
				want_data.push_back(result);
			end
		end
		if (!halted) report_failure("reference run reached its step limit without a halt");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Driving the DUT
	//////////////////////////////////////////////////////////////////////

	task automatic apply_reset();
		@(posedge clock);
		#DRIVE_DELAY;
		reset  = 1'b1;
		run    = 1'b0;
		st_req = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#DRIVE_DELAY;
		reset = 1'b0;
		@(negedge clock);
		check_bit("st_ack", st_ack, 1'b0);
		check_bit("wb_valid", wb_valid, 1'b0);
		check_bit("term", term, 1'b0);
	endtask

	task automatic wait_ack(input logic level, output bit ok);
		ok = 1'b0;
		for (int i = 0; i < ACK_WAIT && !ok; i++) begin
			@(negedge clock);
			if (st_ack === level) ok = 1'b1;
		end
	endtask

	// One four-phase store
	task automatic store_word(input logic [ADDR_WIDTH-1:0] addr, input instr_u word);
		bit ok;
		@(posedge clock);
		#DRIVE_DELAY;
		st_req   = 1'b1;
		st_addr  = addr;
		st_instr = word;
		wait_ack(1'b1, ok);
		if (!ok) report_failure($sformatf("st_ack did not rise for address %0d", addr));
		@(posedge clock);
		#DRIVE_DELAY;
		st_req = 1'b0;
		wait_ack(1'b0, ok);
		if (!ok) report_failure($sformatf("st_ack did not fall for address %0d", addr));
	endtask

	task automatic run_program(input int p);
		bit done;
		current_prog = p;
		apply_reset();
		for (int a = 0; a < prog_len[p]; a++) begin
			store_word(ADDR_WIDTH'(a), prog_words[p][a]);
		end
		for (int a = 0; a < prog_len[p]; a++) begin
			check_instr(a, i_dut.u_instr_store.mem[a], prog_words[p][a]);
		end
		interpret(p);
		@(posedge clock);
		#DRIVE_DELAY;
		run  = 1'b1;
		done = 1'b0;
		// Collect write-backs until the core halts
		while (!done) begin
			@(negedge clock);
			if (wb_valid) begin
				if (want_index.size() == 0) begin
					report_failure($sformatf("unexpected write-back to register %0d", wb_index));
				end else begin
					check_wb(wb_index, wb_data, want_index.pop_front(), want_data.pop_front());
				end
			end
			if (term) done = 1'b1;
		end
		if (want_index.size() != 0) begin
			report_failure($sformatf("%0d write-backs missing at halt", want_index.size()));
		end
		repeat (TAIL_CYCLES) begin
			@(negedge clock);
			check_bit("term", term, 1'b1);
			check_bit("wb_valid", wb_valid, 1'b0);
		end
		@(posedge clock);
		#DRIVE_DELAY;
		run = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		int total;
		reset      = 1'b1;
		run        = 1'b0;
		st_req     = 1'b0;
		st_addr    = '0;
		st_instr   = '0;
		lfsr_state = LFSR_SEED;
		foreach (prog_words[p, i]) prog_words[p][i] = '0;
		load_programs();
		fill_immediates();
		total = 0;
		for (int p = 0; p < NUM_PROGS; p++) begin
			total += prog_steps[p] * 3 + prog_len[p] * 4 + RESET_CYCLES + TAIL_CYCLES + 8;
		end
		timeout_cycles = total;
		for (int p = 0; p < NUM_PROGS; p++) begin
			run_program(p);
		end
		$display("Checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		wait (timeout_cycles > 0);
		repeat (timeout_cycles) @(posedge clock);
		error_count++;
		$display("Timeout: the core hung, no halt within %0d cycles", timeout_cycles);
		$display("Checks %0d, errors %0d", check_count, error_count);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage
	import scalar_pkg::*;
(
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       o_valid,
	input  instr_u                     o_instr,
	input  logic [DATA_WIDTH-1:0]      o_op1,
	input  logic [DATA_WIDTH-1:0]      o_op2,
	output logic                       exe_write,
	output logic [REG_INDEX_WIDTH-1:0] exe_dst,
	output logic [DATA_WIDTH-1:0]      exe_result,
	output logic                       wb_valid,
	output logic [REG_INDEX_WIDTH-1:0] wb_index,
	output logic [DATA_WIDTH-1:0]      wb_data,
	output logic                       redirect,
	output logic [IMM_WIDTH-1:0]       redirect_pc,
	output logic                       halted
);

	logic is_alu;
	logic is_taken;
	logic is_halt;

	// Sticky part of the halt flag
	logic halt_seen;

	//////////////////////////////////////////////////////////////////////
	// ALU and branch decision
	//////////////////////////////////////////////////////////////////////

	// ADDI gets its immediate through op2, so it shares the adder
	always_comb begin
		exe_result = '0;
		is_alu     = 1'b0;
		is_taken   = 1'b0;
		is_halt    = 1'b0;
		case (o_instr.reg_fmt.opcode)
			OP_ADD, OP_ADDI: begin
				exe_result = o_op1 + o_op2;
				is_alu     = 1'b1;
			end
			OP_SUB: begin
				exe_result = o_op1 - o_op2;
				is_alu     = 1'b1;
			end
			OP_AND: begin
				exe_result = o_op1 & o_op2;
				is_alu     = 1'b1;
			end
			OP_OR: begin
				exe_result = o_op1 | o_op2;
				is_alu     = 1'b1;
			end
			OP_XOR: begin
				exe_result = o_op1 ^ o_op2;
				is_alu     = 1'b1;
			end
			OP_JMP:  is_taken = 1'b1;
			OP_BNZ:  is_taken = (o_op1 != '0);
			OP_HALT: is_halt = 1'b1;
			default: ;
		endcase
	end

	// Writes to r0 are dropped here, not in the register file
	assign exe_dst   = o_instr.reg_fmt.dst;
	assign exe_write = o_valid & is_alu & (exe_dst != '0);

	// Halt flushes like a taken branch so nothing younger retires
	assign redirect    = o_valid & (is_taken | is_halt);
	assign redirect_pc = o_instr.imm_fmt.imm;

	//////////////////////////////////////////////////////////////////////
	// Write-back register and halt flag
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_valid  <= 1'b0;
			halt_seen <= 1'b0;
		end else begin
			wb_valid  <= exe_write;
			halt_seen <= halt_seen | (o_valid & is_halt);
		end
	end

	always_ff @(posedge clock) begin
		wb_index <= exe_dst;
		wb_data  <= exe_result;
	end

	// Rises together with the halt redirect
	assign halted = halt_seen | (o_valid & is_halt);

endmodule

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_stage
	import scalar_pkg::*;
#(
	parameter int ADDR_WIDTH = 6
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  run,
	input  logic                  halted,
	input  logic                  redirect,
	input  logic [IMM_WIDTH-1:0]  redirect_pc,
	output logic [ADDR_WIDTH-1:0] fetch_addr,
	input  instr_u                rd_instr,
	output logic                  f_valid,
	output instr_u                f_instr
);

	logic [ADDR_WIDTH-1:0] pc;

	// Set when the memory output holds a word we asked for
	logic word_valid;

	// A read goes out this cycle
	logic issue;

	assign issue = run & ~halted;

	//////////////////////////////////////////////////////////////////////
	// Program counter
	//////////////////////////////////////////////////////////////////////

	// Jump targets are word addresses, upper immediate bits ignored
	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= redirect_pc[ADDR_WIDTH-1:0];
		end else if (issue) begin
			pc <= pc + 1'b1;
		end
	end

	assign fetch_addr = pc;

	//////////////////////////////////////////////////////////////////////
	// Word in flight from memory
	//////////////////////////////////////////////////////////////////////

	// The read issued during a redirect is from the old path, drop it
	always_ff @(posedge clock) begin
		if (reset) begin
			word_valid <= 1'b0;
		end else begin
			word_valid <= issue & ~redirect;
		end
	end

	// Memory output register doubles as the fetch register
	assign f_valid = word_valid;
	assign f_instr = rd_instr;

endmodule

`default_nettype wire

// ==== hw/instr_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_store
	import scalar_pkg::*;
#(
	parameter int ADDR_WIDTH = 6
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  run,
	input  logic                  st_req,
	input  logic [ADDR_WIDTH-1:0] st_addr,
	input  instr_u                st_instr,
	output logic                  st_ack,
	input  logic [ADDR_WIDTH-1:0] fetch_addr,
	output instr_u                rd_instr
);

	localparam int DEPTH = 2 ** ADDR_WIDTH;

	instr_u mem [DEPTH];

	// New request seen while ack is still low and the core is idle
	logic accept;

	assign accept = st_req & ~st_ack & ~run;

	//////////////////////////////////////////////////////////////////////
	// Four-phase store handshake
	//////////////////////////////////////////////////////////////////////

	// Ack rises one cycle after req, drops one cycle after req goes away
	always_ff @(posedge clock) begin
		if (reset) begin
			st_ack <= 1'b0;
		end else if (accept) begin
			st_ack <= 1'b1;
		end else if (st_ack && !st_req) begin
			st_ack <= 1'b0;
		end
	end

	// Word lands on the same edge that raises ack
	always_ff @(posedge clock) begin
		if (accept) begin
			mem[st_addr] <= st_instr;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Fetch read port
	//////////////////////////////////////////////////////////////////////

	// One word per cycle, data valid the cycle after the address
	always_ff @(posedge clock) begin
		rd_instr <= mem[fetch_addr];
	end

endmodule

`default_nettype wire

// ==== hw/operand_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_stage
	import scalar_pkg::*;
(
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       f_valid,
	input  instr_u                     f_instr,
	input  logic                       redirect,
	input  logic                       exe_write,
	input  logic [REG_INDEX_WIDTH-1:0] exe_dst,
	input  logic [DATA_WIDTH-1:0]      exe_result,
	input  logic                       wb_valid,
	input  logic [REG_INDEX_WIDTH-1:0] wb_index,
	input  logic [DATA_WIDTH-1:0]      wb_data,
	output logic                       o_valid,
	output instr_u                     o_instr,
	output logic [DATA_WIDTH-1:0]      o_op1,
	output logic [DATA_WIDTH-1:0]      o_op2
);

	localparam int NUM_REGS = 2 ** REG_INDEX_WIDTH;

	logic [DATA_WIDTH-1:0] regs [NUM_REGS];

	logic [REG_INDEX_WIDTH-1:0] src1;
	logic [REG_INDEX_WIDTH-1:0] src2;
	logic [DATA_WIDTH-1:0]      imm_ext;
	logic                       is_imm;
	logic [DATA_WIDTH-1:0]      src1_value;
	logic [DATA_WIDTH-1:0]      src2_value;

	//////////////////////////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (wb_valid) begin
			regs[wb_index] <= wb_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////////////

	// src1 sits at the same bits in both formats
	assign src1 = f_instr.reg_fmt.src1;
	assign src2 = f_instr.reg_fmt.src2;

	assign imm_ext = {{(DATA_WIDTH - IMM_WIDTH){f_instr.imm_fmt.imm[IMM_WIDTH-1]}},
		f_instr.imm_fmt.imm};

	always_comb begin
		case (f_instr.reg_fmt.opcode)
			OP_ADDI, OP_JMP, OP_BNZ: is_imm = 1'b1;
			default:                 is_imm = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Bypass
	//////////////////////////////////////////////////////////////////////

	// Youngest producer wins, r0 is hardwired to zero
	function automatic logic [DATA_WIDTH-1:0] pick_operand(
		input logic [REG_INDEX_WIDTH-1:0] index,
		input logic [DATA_WIDTH-1:0]      rf_value
	);
		if (index == '0) begin
			return '0;
		end else if (exe_write && exe_dst == index) begin
			return exe_result;
		end else if (wb_valid && wb_index == index) begin
			return wb_data;
		end
		return rf_value;
	endfunction

	always_comb begin
		src1_value = pick_operand(src1, regs[src1]);
		src2_value = pick_operand(src2, regs[src2]);
	end

	//////////////////////////////////////////////////////////////////////
	// Pipeline register
	//////////////////////////////////////////////////////////////////////

	// Redirect kills the instruction moving into execute
	always_ff @(posedge clock) begin
		if (reset) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= f_valid & ~redirect;
		end
	end

	always_ff @(posedge clock) begin
		o_instr <= f_instr;
		o_op1   <= src1_value;
		o_op2   <= is_imm ? imm_ext : src2_value;
	end

endmodule

`default_nettype wire

// ==== hw/scalar_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module scalar_core
	import scalar_pkg::*;
#(
	parameter int ADDR_WIDTH = 6
) (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       run,
	input  logic                       st_req,
	input  logic [ADDR_WIDTH-1:0]      st_addr,
	input  instr_u                     st_instr,
	output logic                       st_ack,
	output logic                       wb_valid,
	output logic [REG_INDEX_WIDTH-1:0] wb_index,
	output logic [DATA_WIDTH-1:0]      wb_data,
	output logic                       term
);

	// Fetch path
	logic [ADDR_WIDTH-1:0] fetch_addr;
	instr_u                rd_instr;
	logic                  f_valid;
	instr_u                f_instr;

	// Operand to execute
	logic                  o_valid;
	instr_u                o_instr;
	logic [DATA_WIDTH-1:0] o_op1;
	logic [DATA_WIDTH-1:0] o_op2;

	// Feedback from execute
	logic                       exe_write;
	logic [REG_INDEX_WIDTH-1:0] exe_dst;
	logic [DATA_WIDTH-1:0]      exe_result;
	logic                       redirect;
	logic [IMM_WIDTH-1:0]       redirect_pc;
	logic                       halted;

	assign term = halted;

	//////////////////////////////////////////////////////////////////////
	// Instruction memory and fetch
	//////////////////////////////////////////////////////////////////////

	instr_store #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_instr_store (
		.clock      (clock),
		.reset      (reset),
		.run        (run),
		.st_req     (st_req),
		.st_addr    (st_addr),
		.st_instr   (st_instr),
		.st_ack     (st_ack),
		.fetch_addr (fetch_addr),
		.rd_instr   (rd_instr)
	);

	fetch_stage #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_fetch_stage (
		.clock       (clock),
		.reset       (reset),
		.run         (run),
		.halted      (halted),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.fetch_addr  (fetch_addr),
		.rd_instr    (rd_instr),
		.f_valid     (f_valid),
		.f_instr     (f_instr)
	);

	//////////////////////////////////////////////////////////////////////
	// Operand read and execute
	//////////////////////////////////////////////////////////////////////

	operand_stage u_operand_stage (
		.clock      (clock),
		.reset      (reset),
		.f_valid    (f_valid),
		.f_instr    (f_instr),
		.redirect   (redirect),
		.exe_write  (exe_write),
		.exe_dst    (exe_dst),
		.exe_result (exe_result),
		.wb_valid   (wb_valid),
		.wb_index   (wb_index),
		.wb_data    (wb_data),
		.o_valid    (o_valid),
		.o_instr    (o_instr),
		.o_op1      (o_op1),
		.o_op2      (o_op2)
	);

	execute_stage u_execute_stage (
		.clock       (clock),
		.reset       (reset),
		.o_valid     (o_valid),
		.o_instr     (o_instr),
		.o_op1       (o_op1),
		.o_op2       (o_op2),
		.exe_write   (exe_write),
		.exe_dst     (exe_dst),
		.exe_result  (exe_result),
		.wb_valid    (wb_valid),
		.wb_index    (wb_index),
		.wb_data     (wb_data),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.halted      (halted)
	);

endmodule

`default_nettype wire

// ==== hw/scalar_pkg.sv ====
`default_nettype none

package scalar_pkg;

	//////////////////////////////////////////////////////////////////////
	// Word and field widths
	//////////////////////////////////////////////////////////////////////

	localparam int DATA_WIDTH      = 32;
	localparam int REG_INDEX_WIDTH = 4;
	localparam int OPCODE_WIDTH    = 4;
	localparam int IMM_WIDTH       = 20;

	// Spare bits at the bottom of a register-format word
	localparam int UNUSED_WIDTH = DATA_WIDTH - OPCODE_WIDTH - 3 * REG_INDEX_WIDTH;

	//////////////////////////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////////////////////////

	// Register format
	localparam logic [OPCODE_WIDTH-1:0] OP_ADD  = 4'h1;
	localparam logic [OPCODE_WIDTH-1:0] OP_SUB  = 4'h2;
	localparam logic [OPCODE_WIDTH-1:0] OP_AND  = 4'h3;
	localparam logic [OPCODE_WIDTH-1:0] OP_OR   = 4'h4;
	localparam logic [OPCODE_WIDTH-1:0] OP_XOR  = 4'h5;

	// Immediate format
	localparam logic [OPCODE_WIDTH-1:0] OP_ADDI = 4'h6;
	localparam logic [OPCODE_WIDTH-1:0] OP_JMP  = 4'h7;
	localparam logic [OPCODE_WIDTH-1:0] OP_BNZ  = 4'h8;

	// Stops the core for good
	localparam logic [OPCODE_WIDTH-1:0] OP_HALT = 4'hf;

	//////////////////////////////////////////////////////////////////////
	// Instruction word, two views of the same 32 bits
	//////////////////////////////////////////////////////////////////////

	typedef union packed {
		struct packed {
			logic [OPCODE_WIDTH-1:0]    opcode;
			logic [REG_INDEX_WIDTH-1:0] dst;
			logic [REG_INDEX_WIDTH-1:0] src1;
			logic [REG_INDEX_WIDTH-1:0] src2;
			logic [UNUSED_WIDTH-1:0]    unused;
		} reg_fmt;
		struct packed {
			logic [OPCODE_WIDTH-1:0]    opcode;
			logic [REG_INDEX_WIDTH-1:0] dst;
			logic [REG_INDEX_WIDTH-1:0] src1;
			logic [IMM_WIDTH-1:0]       imm;
		} imm_fmt;
	} instr_u;

endpackage

`default_nettype wire

// ==== scalar_core.f ====
+incdir+dv
hw/scalar_pkg.sv
hw/instr_store.sv
hw/fetch_stage.sv
hw/operand_stage.sv
hw/execute_stage.sv
hw/scalar_core.sv
dv/tb_scalar_core.sv
